// File: bench/conv1x1_layer_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv1x1_params.svh"

module conv1x1_layer_assert (
	input logic               clk,
	input logic               reset,
	input logic [`CH_OUT-1:0] res_valid,
	input logic               valid_out,
	input logic               pending_full,
	input logic               idx_end
);

	// Lanes share the broadcast, so their strobes match
	a_lanes_agree: assert property (@(posedge clk) disable iff (reset)
		(&res_valid) == (|res_valid))
		else $error("res_valid bits differ between lanes");

	// Pending slot only frees at the last index
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		!(res_valid[0] && valid_out && pending_full && !idx_end))
		else $error("result set arrived while the pending buffer was full");

	a_quiet_in_reset: assert property (@(posedge clk)
		reset |=> !valid_out)
		else $error("valid_out high after a reset cycle");

endmodule

bind conv1x1_layer conv1x1_layer_assert u_conv1x1_layer_assert (
	.clk         (clk),
	.reset       (reset),
	.res_valid   (res_valid),
	.valid_out   (valid_out),
	.pending_full(u_serializer.pending_full),
	.idx_end     (u_serializer.idx_end)
);

`default_nettype wire

// File: bench/conv1x1_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv1x1_params.svh"

module conv1x1_layer_tb
	import conv1x1_pkg::*;
();

	// Data file layout per set: weights, then per pixel the inputs and the expected outputs
	localparam int W_WORDS      = `CH_IN * `CH_OUT;
	localparam int PIXELS       = 16;
	localparam int PIX_STRIDE   = `CH_IN + `CH_OUT;
	localparam int SET_WORDS    = W_WORDS + PIXELS * PIX_STRIDE;
	localparam int NUM_SETS     = 2;
	localparam int TOTAL_WORDS  = NUM_SETS * SET_WORDS;
	localparam int INPUT_WORDS  = NUM_SETS * (W_WORDS + PIXELS * `CH_IN);
	localparam int TIMEOUT_CYCLES = 8 * INPUT_WORDS + 100;
	localparam int LATENCY      = 3;

	logic    clk;
	logic    reset;
	logic    valid_in;
	pixel_t  pxl_in;
	logic    valid_weight_in;
	weight_t weight_in;
	logic    valid_out;
	pixel_t  pxl_out;

	logic [`DATA_W-1:0] testdata [TOTAL_WORDS];
	pixel_t             expected_q [$];

	logic [31:0] rng_state = 32'h65a3_22fd;
	int          cycle = 0;
	int          last_in_cycle = 0;
	logic        latency_armed = 1'b0;
	int          out_count = 0;

	conv1x1_layer u_conv1x1_layer (
		.clk            (clk),
		.reset          (reset),
		.valid_in       (valid_in),
		.pxl_in         (pxl_in),
		.valid_weight_in(valid_weight_in),
		.weight_in      (weight_in),
		.valid_out      (valid_out),
		.pxl_out        (pxl_out)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_on_failure();
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// Idle cycles between input words, 0 to 3
	task automatic pause_random();
		rng_state = xorshift32(rng_state);
		repeat (rng_state[1:0]) begin
			@(negedge clk);
			valid_in        = 1'b0;
			valid_weight_in = 1'b0;
		end
	endtask

	task automatic load_weights(input int base);
		for (int i = 0; i < W_WORDS; i++) begin
			@(negedge clk);
			valid_in        = 1'b0;
			valid_weight_in = 1'b1;
			weight_in       = weight_t'(testdata[base + i]);
			pause_random();
		end
		@(negedge clk);
		valid_weight_in = 1'b0;
	endtask

	task automatic stream_image(input int base);
		int pix_base;
		for (int p = 0; p < PIXELS; p++) begin
			pix_base = base + W_WORDS + p * PIX_STRIDE;
			for (int k = 0; k < `CH_OUT; k++)
				expected_q.push_back(pixel_t'(testdata[pix_base + `CH_IN + k]));
			for (int c = 0; c < `CH_IN; c++) begin
				@(negedge clk);
				valid_weight_in = 1'b0;
				valid_in        = 1'b1;
				pxl_in          = pixel_t'(testdata[pix_base + c]);
				// First pixel after a weight load meets an idle serializer
				if (p == 0 && c == `CH_IN - 1) begin
					last_in_cycle = cycle;
					latency_armed = 1'b1;
				end
				pause_random();
			end
		end
		@(negedge clk);
		valid_in = 1'b0;
	endtask

	task automatic wait_drained();
		while (expected_q.size() != 0)
			@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		reset           = 1'b1;
		valid_in        = 1'b0;
		pxl_in          = '0;
		valid_weight_in = 1'b0;
		weight_in       = '0;
		$readmemh("bench/conv1x1_testdata.txt", testdata);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int s = 0; s < NUM_SETS; s++) begin
			load_weights(s * SET_WORDS);
			stream_image(s * SET_WORDS);
			wait_drained();
		end

		// Catch any stray words after the last pixel
		repeat (`CH_OUT + 4) @(negedge clk);
		if (expected_q.size() == 0 && out_count == NUM_SETS * PIXELS * `CH_OUT) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Output count %0d does not match the expected word count", out_count);
			$display("Testbench failed");
			$fatal(1, "output count mismatch");
		end
	end

	////////////////////////////////////////////////////////////
	// Output checker
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		pixel_t exp_val;
		if (!reset) begin
			if (valid_out) begin
				if (expected_q.size() == 0) begin
					$display("Output word appeared when no output was expected");
					stop_on_failure();
				end
				exp_val = expected_q.pop_front();
				assert (pxl_out == exp_val) else begin
					$display("[ERROR] pxl_out got %h expected %h", pxl_out, exp_val);
					stop_on_failure();
				end
				if (latency_armed) begin
					assert (cycle - last_in_cycle == LATENCY) else begin
						$display("[ERROR] valid_out latency got %h expected %h",
							cycle - last_in_cycle, LATENCY);
						stop_on_failure();
					end
					latency_armed = 1'b0;
				end
				out_count++;
			end else begin
				// A pixel's outputs form one unbroken run
				assert (out_count % `CH_OUT == 0) else begin
					$display("valid_out dropped in the middle of a pixel's output run");
					stop_on_failure();
				end
			end
		end
	end

	// Timeout
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_on_failure();
		end
	end

endmodule

`default_nettype wire

// File: bench/conv1x1_testdata.txt
// Weight lines: one output channel each, input channels 0..3
// Pixel lines: inputs ch0 ch1 ch2 ch3, then expected outputs ch0 ch1 ch2 ch3
// Weight set A
10 00 00 00
00 10 00 00
20 20 20 20
F0 F0 F0 F0
// Image A
01 02 03 04 01 02 14 F6
00 00 00 00 00 00 00 00
64 64 00 00 64 64 7F 80
9C 9C 00 00 9C 9C 80 7F
7F 7F 7F 7F 7F 7F 7F 80
80 80 80 80 80 80 80 7F
0A EC 1E FB 0A EC 1E F1
32 0D 00 00 32 0D 7E C1
20 20 00 00 20 20 7F C0
E0 E0 00 00 E0 E0 80 40
DF E0 00 00 DF E0 80 41
40 40 00 00 40 40 7F 80
C0 C0 00 01 C0 C0 80 7F
05 F9 09 F5 05 F9 F8 04
00 00 7F 02 00 00 7F 80
07 00 00 F9 07 00 00 00
// Weight set B
00 00 10 00
00 00 00 10
08 08 08 08
E0 00 00 20
// Image B
01 02 03 04 03 04 05 06
00 00 FF 00 FF 00 FF 00
64 00 00 9C 00 9C 00 80
9C 00 00 64 00 64 00 7F
7F 7F 7F 7F 7F 7F 7F 00
80 80 80 80 80 80 80 00
03 00 00 00 00 00 01 FA
FD 00 00 00 00 00 FE 06
0A 14 1E 28 1E 28 32 3C
F6 EC E2 D8 E2 D8 CE C4
00 00 00 40 00 40 20 7F
40 00 00 00 00 00 20 80
00 00 00 3F 00 3F 1F 7E
00 00 F9 FF F9 FF FC FE
01 01 01 FE 01 FE 00 FA
09 F7 05 05 05 05 05 F8

// File: hdl/conv1x1_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv1x1_params.svh"

module conv1x1_layer
	import conv1x1_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    valid_in,
	input  pixel_t  pxl_in,
	input  logic    valid_weight_in,
	input  weight_t weight_in,
	output logic    valid_out,
	output pixel_t  pxl_out
);

	// Broadcast bus to the lanes
	logic     bcast_valid;
	pixel_t   bcast_pxl;
	chan_in_t bcast_chan;
	logic     bcast_last;

	// Weight write bus
	logic [`CH_OUT-1:0] wr_en;
	chan_in_t           wr_chan;
	weight_t            wr_data;

	// Lane results
	logic [`CH_OUT-1:0]   res_valid;
	pixel_t [`CH_OUT-1:0] res_data;

	conv_input_distributor u_distributor (
		.clk            (clk),
		.reset          (reset),
		.valid_in       (valid_in),
		.pxl_in         (pxl_in),
		.valid_weight_in(valid_weight_in),
		.weight_in      (weight_in),
		.bcast_valid    (bcast_valid),
		.bcast_pxl      (bcast_pxl),
		.bcast_chan     (bcast_chan),
		.bcast_last     (bcast_last),
		.wr_en          (wr_en),
		.wr_chan        (wr_chan),
		.wr_data        (wr_data)
	);

	////////////////////////////////////////////////////////////
	// One MAC lane per output channel
	////////////////////////////////////////////////////////////

	for (genvar k = 0; k < `CH_OUT; k++) begin : g_lane
		conv_mac_lane u_lane (
			.clk        (clk),
			.reset      (reset),
			.bcast_valid(bcast_valid),
			.bcast_pxl  (bcast_pxl),
			.bcast_chan (bcast_chan),
			.bcast_last (bcast_last),
			.wr_en      (wr_en[k]),
			.wr_chan    (wr_chan),
			.wr_data    (wr_data),
			.res_valid  (res_valid[k]),
			.res_data   (res_data[k])
		);
	end

	conv_output_serializer u_serializer (
		.clk      (clk),
		.reset    (reset),
		.res_valid(res_valid),
		.res_data (res_data),
		.valid_out(valid_out),
		.pxl_out  (pxl_out)
	);

endmodule

`default_nettype wire

// File: hdl/conv1x1_params.svh
`ifndef CONV1X1_PARAMS_SVH
`define CONV1X1_PARAMS_SVH

////////////////////////////////////////////////////////////
// Word widths
////////////////////////////////////////////////////////////

// Pixel, weight and output words
`define DATA_W 8

// Lane accumulator, wide enough for CH_IN full-scale products
`define ACC_W 20

// Fixed point shift applied before saturation
`define FRAC_BITS 4

////////////////////////////////////////////////////////////
// Layer shape
////////////////////////////////////////////////////////////

// Input channels per pixel
`define CH_IN 4

// Output channels, one MAC lane each
// Must not exceed CH_IN
`define CH_OUT 4

`endif

// File: hdl/conv1x1_pkg.sv
`default_nettype none

`include "conv1x1_params.svh"

package conv1x1_pkg;

	// Index widths, at least one bit
	localparam int CHAN_IN_W  = (`CH_IN > 1) ? $clog2(`CH_IN) : 1;
	localparam int CHAN_OUT_W = (`CH_OUT > 1) ? $clog2(`CH_OUT) : 1;

	typedef logic signed [`DATA_W-1:0] pixel_t;
	typedef logic signed [`DATA_W-1:0] weight_t;
	typedef logic signed [`ACC_W-1:0]  acc_t;

	typedef logic [CHAN_IN_W-1:0]  chan_in_t;
	typedef logic [CHAN_OUT_W-1:0] chan_out_t;

	// Output serializer states
	typedef enum logic {
		SER_IDLE,
		SER_EMIT
	} ser_state_t;

endpackage

`default_nettype wire

// File: hdl/conv_input_distributor.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv1x1_params.svh"

module conv_input_distributor
	import conv1x1_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  pixel_t            pxl_in,
	input  logic              valid_weight_in,
	input  weight_t           weight_in,
	output logic              bcast_valid,
	output pixel_t            bcast_pxl,
	output chan_in_t          bcast_chan,
	output logic              bcast_last,
	output logic [`CH_OUT-1:0] wr_en,
	output chan_in_t          wr_chan,
	output weight_t           wr_data
);

	localparam chan_in_t  CHAN_IN_LAST  = chan_in_t'(`CH_IN - 1);
	localparam chan_out_t CHAN_OUT_LAST = chan_out_t'(`CH_OUT - 1);

	chan_in_t  pix_chan;
	chan_in_t  w_chan;
	chan_out_t w_lane;

	////////////////////////////////////////////////////////////
	// Position counters
	////////////////////////////////////////////////////////////

	// Pixel words come channel by channel
	always_ff @(posedge clk) begin
		if (reset) begin
			pix_chan <= '0;
		end else if (valid_in) begin
			pix_chan <= (pix_chan == CHAN_IN_LAST) ? '0 : pix_chan + 1'b1;
		end
	end

	// Weights are output-channel major, so the lane steps once per CH_IN words
	always_ff @(posedge clk) begin
		if (reset) begin
			w_chan <= '0;
			w_lane <= '0;
		end else if (valid_weight_in) begin
			if (w_chan == CHAN_IN_LAST) begin
				w_chan <= '0;
				w_lane <= (w_lane == CHAN_OUT_LAST) ? '0 : w_lane + 1'b1;
			end else begin
				w_chan <= w_chan + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Registered broadcast and weight write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			bcast_valid <= 1'b0;
			wr_en       <= '0;
		end else begin
			bcast_valid <= valid_in;
			// One-hot lane select
			wr_en <= '0;
			if (valid_weight_in)
				wr_en[w_lane] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		bcast_pxl  <= pxl_in;
		bcast_chan <= pix_chan;
		bcast_last <= (pix_chan == CHAN_IN_LAST);
		wr_chan    <= w_chan;
		wr_data    <= weight_in;
	end

endmodule

`default_nettype wire

// File: hdl/conv_mac_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv1x1_params.svh"

module conv_mac_lane
	import conv1x1_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     bcast_valid,
	input  pixel_t   bcast_pxl,
	input  chan_in_t bcast_chan,
	input  logic     bcast_last,
	input  logic     wr_en,
	input  chan_in_t wr_chan,
	input  weight_t  wr_data,
	output logic     res_valid,
	output pixel_t   res_data
);

	localparam acc_t SAT_MAX = acc_t'((1 <<< (`DATA_W - 1)) - 1);
	localparam acc_t SAT_MIN = acc_t'(-(1 <<< (`DATA_W - 1)));

	weight_t weights [`CH_IN];

	logic signed [2*`DATA_W-1:0] product;
	acc_t acc;
	acc_t sum;

	// Floor shift, then clamp into the output word range
	function automatic pixel_t saturate(input acc_t value);
		acc_t shifted;
		shifted = value >>> `FRAC_BITS;
		if (shifted > SAT_MAX)
			return pixel_t'(SAT_MAX);
		else if (shifted < SAT_MIN)
			return pixel_t'(SAT_MIN);
		else
			return shifted[`DATA_W-1:0];
	endfunction

	// Weight store for this output channel
	always_ff @(posedge clk) begin
		if (wr_en)
			weights[wr_chan] <= wr_data;
	end

	////////////////////////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////////////////////////

	always_comb begin
		product = bcast_pxl * weights[bcast_chan];
		// Channel 0 starts a new pixel
		sum     = (bcast_chan == '0) ? acc_t'(product) : acc + product;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			acc       <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= bcast_valid & bcast_last;
			if (bcast_valid)
				acc <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (bcast_valid && bcast_last)
			res_data <= saturate(sum);
	end

endmodule

`default_nettype wire

// File: hdl/conv_output_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv1x1_params.svh"

module conv_output_serializer
	import conv1x1_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`CH_OUT-1:0]        res_valid,
	input  pixel_t [`CH_OUT-1:0]      res_data,
	output logic                      valid_out,
	output pixel_t                    pxl_out
);

	localparam chan_out_t IDX_LAST = chan_out_t'(`CH_OUT - 1);

	ser_state_t state;
	chan_out_t  idx;
	logic       pending_full;
	logic       set_in;
	logic       idx_end;

	pixel_t [`CH_OUT-1:0] active_buf;
	pixel_t [`CH_OUT-1:0] pending_buf;

	// All lanes strobe together, bit 0 stands for the set
	assign set_in  = res_valid[0];
	assign idx_end = (idx == IDX_LAST);

	////////////////////////////////////////////////////////////
	// State and index
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= SER_IDLE;
			idx          <= '0;
			pending_full <= 1'b0;
		end else begin
			case (state)
				SER_IDLE: begin
					idx <= '0;
					if (set_in)
						state <= SER_EMIT;
				end
				SER_EMIT: begin
					if (!idx_end) begin
						idx <= idx + 1'b1;
						if (set_in)
							pending_full <= 1'b1;
					end else begin
						idx <= '0;
						// Chain straight into the next set if one is waiting
						if (pending_full)
							pending_full <= set_in;
						else if (!set_in)
							state <= SER_IDLE;
					end
				end
				default: state <= SER_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Result buffers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == SER_IDLE) begin
			if (set_in)
				active_buf <= res_data;
		end else if (idx_end) begin
			if (pending_full)
				active_buf <= pending_buf;
			else if (set_in)
				active_buf <= res_data;
		end
	end

	// Holds a set that lands mid-emission
	always_ff @(posedge clk) begin
		if (state == SER_EMIT && set_in && (!idx_end || pending_full))
			pending_buf <= res_data;
	end

	assign valid_out = (state == SER_EMIT);
	assign pxl_out   = active_buf[idx];

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/conv1x1_pkg.sv
hdl/conv_input_distributor.sv
hdl/conv_mac_lane.sv
hdl/conv_output_serializer.sv
hdl/conv1x1_layer.sv
bench/conv1x1_layer_assert.sv
bench/conv1x1_layer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module conv1x1_layer_tb \
	-f project.f -o conv1x1_sim &&
sim_out="$(./obj_dir/conv1x1_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "Testbench passed" && exit 0 || exit 1
